/* design/input_port.sv */
// One router input. The upstream sender must hold its flit while stop_o is high
`timescale 1ns/1ps
`default_nettype none

module input_port #(
  parameter int queue_depth = 4
) (
  input  logic                   clk,
  input  logic                   rst,
  input  noc_router_pkg::xy_t    position_i,
  input  noc_router_pkg::flit_t  data_i,
  input  logic                   void_i,
  input  logic                   rd_i,
  output logic                   stop_o,
  output noc_router_pkg::flit_t  head_o,
  output logic                   valid_o,
  output noc_router_pkg::route_t request_o,
  output noc_router_pkg::route_t next_route_o
);
  import noc_router_pkg::*;

  logic   empty;
  logic   head_valid;
  logic   tail_valid;
  route_t saved_request;

  input_queue #(
    .queue_depth(queue_depth)
  ) u_queue (
    .clk(clk),
    .rst(rst),
    .wr_i(~void_i),
    .rd_i(rd_i),
    .data_i(data_i),
    .data_o(head_o),
    .empty_o(empty),
    .full_o(stop_o)
  );

  // Head of queue is real when stored, or when the bypass shows a live arrival
  assign valid_o = ~empty | ~void_i;
  assign head_valid = valid_o & head_o.header.preamble.head;
  assign tail_valid = valid_o & head_o.header.preamble.tail;

  // Body flits keep asking for the output that the head asked for
  always_ff @(posedge clk) begin
    if (rst) begin
      saved_request <= '0;
    end else if (tail_valid) begin
      saved_request <= '0;
    end else if (head_valid) begin
      saved_request <= head_o.header.routing;
    end
  end

  assign request_o = head_valid ? head_o.header.routing : saved_request;

  lookahead_route u_lookahead (
    .position_i(position_i),
    .destination_i(head_o.header.destination),
    .route_i(head_o.header.routing),
    .next_route_o(next_route_o)
  );

endmodule

`default_nettype wire

/* design/input_queue.sv */
// Flit FIFO, bypassed when empty. Depth must be 2 or more and writes to a full queue are dropped
`timescale 1ns/1ps
`default_nettype none

module input_queue #(
  parameter int queue_depth = 4
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wr_i,
  input  logic                  rd_i,
  input  noc_router_pkg::flit_t data_i,
  output noc_router_pkg::flit_t data_o,
  output logic                  empty_o,
  output logic                  full_o
);
  import noc_router_pkg::*;

  localparam int ptr_width = $clog2(queue_depth);
  localparam int count_width = $clog2(queue_depth + 1);

  flit_t                  mem [queue_depth];
  logic [ptr_width-1:0]   wr_ptr;
  logic [ptr_width-1:0]   rd_ptr;
  logic [count_width-1:0] count;
  logic                   push;
  logic                   pop;

  // Wrap explicitly so that depths other than powers of two work
  function automatic logic [ptr_width-1:0] ptr_step(input logic [ptr_width-1:0] ptr);
    if (ptr == ptr_width'(queue_depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty_o = (count == '0);
  assign full_o = (count == count_width'(queue_depth));

  // An arrival read out at once through the bypass never enters storage
  assign push = wr_i & ~full_o & ~(empty_o & rd_i);
  assign pop = rd_i & ~empty_o;

  assign data_o = empty_o ? data_i : mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_step(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_step(rd_ptr);
      end
      // Occupancy
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* design/lookahead_route.sv */
// XY routing for the next hop. Steps off the mesh edge wrap and give meaningless results
`timescale 1ns/1ps
`default_nettype none

module lookahead_route (
  input  noc_router_pkg::xy_t    position_i,
  input  noc_router_pkg::xy_t    destination_i,
  input  noc_router_pkg::route_t route_i,
  output noc_router_pkg::route_t next_route_o
);
  import noc_router_pkg::*;

  xy_t neighbour;

  // Coordinates of the router this flit reaches next
  always_comb begin
    neighbour = position_i;
    case (route_i)
      go_north: neighbour.y = position_i.y - 1'b1;
      go_south: neighbour.y = position_i.y + 1'b1;
      go_west:  neighbour.x = position_i.x - 1'b1;
      go_east:  neighbour.x = position_i.x + 1'b1;
      // Local or no request stays here
      default:  neighbour = position_i;
    endcase
  end

  // X first, then Y, as seen from the neighbour
  always_comb begin
    if (route_i == go_local) begin
      next_route_o = go_local;
    end else if (destination_i.x < neighbour.x) begin
      next_route_o = go_west;
    end else if (destination_i.x > neighbour.x) begin
      next_route_o = go_east;
    end else if (destination_i.y < neighbour.y) begin
      next_route_o = go_north;
    end else if (destination_i.y > neighbour.y) begin
      next_route_o = go_south;
    end else begin
      next_route_o = go_local;
    end
  end

endmodule

`default_nettype wire

/* design/mesh_router.sv */
// Five-port XY mesh router with stop/void links. position_i must stay stable while traffic flows
`timescale 1ns/1ps
`default_nettype none

module mesh_router #(
  parameter int queue_depth = 4
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  noc_router_pkg::xy_t                   position_i,
  input  noc_router_pkg::port_flits_t           data_i,
  input  logic [noc_router_pkg::num_ports-1:0]  void_i,
  output logic [noc_router_pkg::num_ports-1:0]  stop_o,
  output noc_router_pkg::port_flits_t           data_o,
  output logic [noc_router_pkg::num_ports-1:0]  void_o,
  input  logic [noc_router_pkg::num_ports-1:0]  stop_i
);
  import noc_router_pkg::*;

  port_flits_t                         heads;
  logic [num_ports-1:0]                valid;
  route_t [num_ports-1:0]              requests;
  route_t [num_ports-1:0]              next_routes;
  logic [num_ports-1:0][num_ports-2:0] out_requests;
  logic [num_ports-1:0][num_ports-1:0] rd_matrix;
  logic [num_ports-1:0]                rd_any;

  ////////////////////
  // Inputs
  ////////////////////

  for (genvar i = 0; i < num_ports; i++) begin : g_input
    input_port #(
      .queue_depth(queue_depth)
    ) u_input (
      .clk(clk),
      .rst(rst),
      .position_i(position_i),
      .data_i(data_i[i]),
      .void_i(void_i[i]),
      .rd_i(rd_any[i]),
      .stop_o(stop_o[i]),
      .head_o(heads[i]),
      .valid_o(valid[i]),
      .request_o(requests[i]),
      .next_route_o(next_routes[i])
    );
  end

  ////////////////////
  // Outputs
  ////////////////////

  for (genvar o = 0; o < num_ports; o++) begin : g_output
    // Requests towards output o, the output's own input left out
    for (genvar i = 0; i < num_ports; i++) begin : g_req
      if (i < o) begin : g_below
        assign out_requests[o][i] = requests[i][o];
      end else if (i > o) begin : g_above
        assign out_requests[o][i-1] = requests[i][o];
      end
    end

    output_port #(
      .port_index(o)
    ) u_output (
      .clk(clk),
      .rst(rst),
      .heads_i(heads),
      .valid_i(valid),
      .next_routes_i(next_routes),
      .request_i(out_requests[o]),
      .stop_i(stop_i[o]),
      .rd_o(rd_matrix[o]),
      .data_o(data_o[o]),
      .void_o(void_o[o])
    );
  end

  // An input is read when any output takes its head
  always_comb begin
    rd_any = '0;
    for (int o = 0; o < num_ports; o++) begin
      rd_any = rd_any | rd_matrix[o];
    end
  end

endmodule

`default_nettype wire

/* design/noc_router_pkg.sv */
// Shared flit layout and routing types. Coordinates are 3 bits wide, so a mesh is at most 8 x 8
`default_nettype none

package noc_router_pkg;

  ////////////////////
  // Mesh coordinates
  ////////////////////

  localparam int coord_width = 3;

  typedef struct packed {
    logic [coord_width-1:0] x;
    logic [coord_width-1:0] y;
  } xy_t;

  ////////////////////
  // Ports and routing
  ////////////////////

  localparam int num_ports = 5;

  typedef enum logic [2:0] {
    port_north = 3'd0,
    port_south = 3'd1,
    port_west  = 3'd2,
    port_east  = 3'd3,
    port_local = 3'd4
  } port_e;

  // One-hot request, all zeros means no request
  typedef logic [num_ports-1:0] route_t;

  localparam route_t go_north = route_t'(1) << port_north;
  localparam route_t go_south = route_t'(1) << port_south;
  localparam route_t go_west  = route_t'(1) << port_west;
  localparam route_t go_east  = route_t'(1) << port_east;
  localparam route_t go_local = route_t'(1) << port_local;

  ////////////////////
  // Flit layout
  ////////////////////

  // Carried along but never looked at by the router
  typedef enum logic [4:0] {
    msg_request   = 5'd0,
    msg_response  = 5'd1,
    msg_interrupt = 5'd2,
    msg_config    = 5'd3
  } msg_e;

  typedef struct packed {
    logic head;
    logic tail;
  } preamble_t;

  localparam int data_width = 32;
  localparam int reserved_width = data_width - 2 * $bits(xy_t) - $bits(msg_e) - num_ports;

  typedef struct packed {
    preamble_t                 preamble;
    xy_t                       source;
    xy_t                       destination;
    msg_e                      message;
    logic [reserved_width-1:0] reserved;
    route_t                    routing;
  } header_t;

  typedef union packed {
    header_t                                 header;
    logic [data_width+$bits(preamble_t)-1:0] raw;
  } flit_t;

  typedef flit_t [num_ports-1:0] port_flits_t;

endpackage

`default_nettype wire

/* design/output_port.sv */
// One router output with a single register stage. data_o and void_o hold while stop_i is high
`timescale 1ns/1ps
`default_nettype none

module output_port #(
  parameter int port_index = 0
) (
  input  logic                                                    clk,
  input  logic                                                    rst,
  input  noc_router_pkg::port_flits_t                             heads_i,
  input  logic [noc_router_pkg::num_ports-1:0]                    valid_i,
  input  noc_router_pkg::route_t [noc_router_pkg::num_ports-1:0]  next_routes_i,
  input  logic [3:0]                                              request_i,
  input  logic                                                    stop_i,
  output logic [noc_router_pkg::num_ports-1:0]                    rd_o,
  output noc_router_pkg::flit_t                                   data_o,
  output logic                                                    void_o
);
  import noc_router_pkg::*;

  logic [3:0]           grant;
  logic                 grant_valid;
  logic [3:0]           config_sel;
  logic                 forwarding;
  logic                 tail_done;
  logic                 go;
  logic [num_ports-1:0] select;
  flit_t                sel_flit;
  flit_t                out_flit;
  logic                 sel_valid;
  route_t               sel_next_route;
  logic                 insert_route;
  logic                 head_done;

  assign go = ~stop_i;

  rr_arbiter u_arbiter (
    .clk(clk),
    .rst(rst),
    .request_i(request_i),
    .tail_done_i(tail_done),
    .grant_o(grant),
    .grant_valid_o(grant_valid)
  );

  worm_fsm u_fsm (
    .clk(clk),
    .rst(rst),
    .grant_i(grant),
    .grant_valid_i(grant_valid),
    .go_i(go),
    .flit_tail_i(sel_flit.header.preamble.tail),
    .flit_valid_i(sel_valid),
    .config_o(config_sel),
    .forwarding_o(forwarding),
    .tail_done_o(tail_done)
  );

  ////////////////////
  // Crossbar
  ////////////////////

  // Spread the 4-wide configuration over all inputs, skipping our own
  always_comb begin
    select = '0;
    for (int j = 0; j < num_ports; j++) begin
      if (j < port_index) begin
        select[j] = config_sel[j];
      end else if (j > port_index) begin
        select[j] = config_sel[j-1];
      end
    end
  end

  always_comb begin
    sel_flit = '0;
    sel_valid = 1'b0;
    sel_next_route = '0;
    for (int j = 0; j < num_ports; j++) begin
      if (select[j]) begin
        sel_flit = heads_i[j];
        sel_valid = valid_i[j];
        sel_next_route = next_routes_i[j];
      end
    end
  end

  // Head flit leaves with the request for the neighbour
  always_comb begin
    out_flit = sel_flit;
    if (insert_route) begin
      out_flit.header.routing = sel_next_route;
    end
  end

  assign head_done = forwarding & sel_valid & sel_flit.header.preamble.head;
  assign rd_o = (forwarding & sel_valid) ? select : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      insert_route <= 1'b1;
    end else if (tail_done) begin
      insert_route <= 1'b1;
    end else if (head_done) begin
      insert_route <= 1'b0;
    end
  end

  ////////////////////
  // Output register
  ////////////////////

  always_ff @(posedge clk) begin
    if (forwarding && sel_valid) begin
      data_o <= out_flit;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      void_o <= 1'b1;
    end else if (go) begin
      void_o <= ~(forwarding & sel_valid);
    end
  end

endmodule

`default_nettype wire

/* design/rr_arbiter.sv */
// Round-robin among four requesters. A grant stays locked until its worm's tail is forwarded
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter (
  input  logic       clk,
  input  logic       rst,
  input  logic [3:0] request_i,
  input  logic       tail_done_i,
  output logic [3:0] grant_o,
  output logic       grant_valid_o
);

  localparam int num_req = 4;

  logic [1:0] pointer;
  logic [1:0] pick_idx;
  logic [1:0] held_idx;
  logic [1:0] grant_idx;
  logic       found;
  logic       locked;

  // First requester at or after the pointer
  always_comb begin
    logic [1:0] idx;
    pick_idx = pointer;
    found = 1'b0;
    for (int i = 0; i < num_req; i++) begin
      idx = pointer + 2'(i);
      if (!found && request_i[idx]) begin
        pick_idx = idx;
        found = 1'b1;
      end
    end
  end

  assign grant_idx = locked ? held_idx : pick_idx;
  assign grant_valid_o = locked | found;
  assign grant_o = grant_valid_o ? (4'b0001 << grant_idx) : 4'b0000;

  always_ff @(posedge clk) begin
    if (rst) begin
      pointer <= '0;
      held_idx <= '0;
      locked <= 1'b0;
    end else if (tail_done_i) begin
      // Worm finished, next search starts after the winner
      pointer <= grant_idx + 1'b1;
      locked <= 1'b0;
    end else if (found && !locked) begin
      held_idx <= pick_idx;
      locked <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* design/worm_fsm.sv */
// Tracks one output between head and payload flits. Configuration is one-hot over the other four inputs
`timescale 1ns/1ps
`default_nettype none

module worm_fsm (
  input  logic       clk,
  input  logic       rst,
  input  logic [3:0] grant_i,
  input  logic       grant_valid_i,
  input  logic       go_i,
  input  logic       flit_tail_i,
  input  logic       flit_valid_i,
  output logic [3:0] config_o,
  output logic       forwarding_o,
  output logic       tail_done_o
);

  typedef enum logic {
    st_head    = 1'b0,
    st_payload = 1'b1
  } state_e;

  state_e     state;
  state_e     state_next;
  logic [3:0] saved_config;

  always_comb begin
    state_next = state;
    config_o = '0;
    forwarding_o = 1'b0;
    case (state)
      st_head: begin
        if (grant_valid_i) begin
          config_o = grant_i;
          forwarding_o = go_i;
          // Single-flit packets never leave the head state
          if (go_i && flit_valid_i && !flit_tail_i) begin
            state_next = st_payload;
          end
        end
      end
      st_payload: begin
        config_o = saved_config;
        forwarding_o = go_i;
        if (go_i && flit_valid_i && flit_tail_i) begin
          state_next = st_head;
        end
      end
      default: state_next = st_head;
    endcase
  end

  assign tail_done_o = forwarding_o & flit_valid_i & flit_tail_i;

  always_ff @(posedge clk) begin
    if (state == st_head && grant_valid_i && go_i) begin
      saved_config <= grant_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_head;
    end else begin
      state <= state_next;
    end
  end

endmodule

`default_nettype wire

/* sim.f */
design/noc_router_pkg.sv
design/input_queue.sv
design/lookahead_route.sv
design/input_port.sv
design/rr_arbiter.sv
design/worm_fsm.sv
design/output_port.sv
design/mesh_router.sv
verification/tb_mesh_router.sv

/* verification/router_golden.txt */
# First data line is the router position x y. Ports are N 0, S 1, W 2, E 3, L 4
# test in0 dx0 dy0 n0 pay0 in1 dx1 dy1 n1 pay1 hold out0 out1 la0 la1 (n1 0 means no packet 1)
3 3
# Single flits towards every side
1 4 1 3 1 0000a001 0 0 0 0 00000000 0 2 0 00100 00000
2 4 5 2 1 0000a002 0 0 0 0 00000000 0 3 0 01000 00000
3 4 3 0 1 0000a003 0 0 0 0 00000000 0 0 0 00001 00000
4 4 3 4 1 0000a004 0 0 0 0 00000000 0 1 0 10000 00000
5 4 2 5 1 0000a005 0 0 0 0 00000000 0 2 0 00010 00000
6 0 3 3 1 0000a006 0 0 0 0 00000000 0 4 0 10000 00000
7 4 4 3 1 0000a007 0 0 0 0 00000000 0 3 0 10000 00000
# Multi-flit worm on an idle router
8 2 6 3 4 0000b000 0 0 0 0 00000000 0 3 0 01000 00000
# North and west worms contend for east
9 0 7 3 3 0000c000 2 5 1 3 0000d000 0 3 3 01000 01000
# East output stopped for 12 cycles
10 4 6 2 6 0000e000 0 0 0 0 00000000 12 3 0 01000 00000
# Worms to different outputs at once
11 1 0 3 3 00010000 3 3 6 2 00020000 0 2 1 00100 00010
12 2 3 1 2 00030000 4 4 5 3 00040000 0 0 3 00001 00010

/* verification/tb_mesh_router.sv */
// Runs at queue depth 4 and must be started from the project root to find the golden file
`timescale 1ns/1ps
`default_nettype none

module tb_mesh_router;
  import noc_router_pkg::*;

  localparam int queue_depth = 4;
  localparam int max_flits = 16;
  localparam int wait_limit = 200;

  logic                 clk;
  logic                 rst;
  xy_t                  position_i;
  port_flits_t          data_i;
  logic [num_ports-1:0] void_i;
  logic [num_ports-1:0] stop_o;
  port_flits_t          data_o;
  logic [num_ports-1:0] void_o;
  logic [num_ports-1:0] stop_i;

  // Flits seen per output, and the streams expected there
  flit_t got_flit [num_ports][2*max_flits];
  int    got_cyc [num_ports][2*max_flits];
  int    got_n [num_ports];
  flit_t exp_flit [num_ports][2*max_flits];
  int    exp_n [num_ports];
  flit_t drv_flit [2][max_flits];

  // Fields of the current golden line, two packets per test
  int          pkt_in [2];
  int          pkt_dx [2];
  int          pkt_dy [2];
  int          pkt_n [2];
  logic [31:0] pkt_pay [2];
  int          pkt_out [2];
  route_t      pkt_la [2];
  int          hold;

  int    cyc;
  int    seed;
  int    fd;
  string line;
  int    cur_test;
  int    test_errors;
  int    tests_run;
  int    tests_failed;
  bit    aborted;

  mesh_router #(
    .queue_depth(queue_depth)
  ) dut0 (
    .clk(clk),
    .rst(rst),
    .position_i(position_i),
    .data_i(data_i),
    .void_i(void_i),
    .stop_o(stop_o),
    .data_o(data_o),
    .void_o(void_o),
    .stop_i(stop_i)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  ////////////////////
  // Output monitor
  ////////////////////

  // A flit counts as taken when it is non-void and the output is not stopped
  always @(negedge clk) begin
    if (!rst) begin
      for (int o = 0; o < num_ports; o++) begin
        if (!void_o[o] && !stop_i[o] && got_n[o] < 2 * max_flits) begin
          got_flit[o][got_n[o]] = data_o[o];
          got_cyc[o][got_n[o]] = cyc;
          got_n[o]++;
        end
      end
    end
  end

  task automatic report_error(input string msg);
    $display("error at %0t ns: test %0d: %s", $time, cur_test, msg);
    test_errors++;
  endtask

  task automatic abort_run(input string why);
    $display("run stopped at %0t ns: %s", $time, why);
    test_errors++;
    aborted = 1'b1;
  endtask

  task automatic finish_test();
    $display("test %0d %s", cur_test, (test_errors == 0) ? "passed" : "failed");
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
    end
  endtask

  // Skips comment and blank lines
  task automatic next_data_line(output bit found);
    int code;
    found = 1'b0;
    while (!found && !$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 1 && line[0] != "#") begin
        found = 1'b1;
      end
    end
  endtask

  function automatic flit_t build_flit(input int j, input int k);
    flit_t f;
    f = '0;
    if (k == 0) begin
      f.header.preamble.head = 1'b1;
      f.header.preamble.tail = (pkt_n[j] == 1);
      f.header.source.x = coord_width'(pkt_in[j]);
      f.header.source.y = coord_width'(j);
      f.header.destination.x = coord_width'(pkt_dx[j]);
      f.header.destination.y = coord_width'(pkt_dy[j]);
      f.header.message = msg_request;
      f.header.reserved = pkt_pay[j][9:0];
      // Request for this router, as the upstream lookahead would have set it
      f.header.routing = route_t'(1) << pkt_out[j];
    end else begin
      f.raw[data_width-1:0] = pkt_pay[j] + k;
      f.header.preamble.tail = (k == pkt_n[j] - 1);
    end
    return f;
  endfunction

  function automatic bit all_arrived();
    for (int o = 0; o < num_ports; o++) begin
      if (got_n[o] < exp_n[o]) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  ////////////////////
  // One test
  ////////////////////

  task automatic run_test();
    int    idx [2];
    bit    take [2];
    int    drive_cyc [2];
    int    hold_left;
    int    waited;
    int    o0;
    flit_t held_data;
    logic  held_void;
    test_errors = 0;
    o0 = pkt_out[0];
    for (int o = 0; o < num_ports; o++) begin
      got_n[o] = 0;
      exp_n[o] = 0;
    end
    // Packet 0 is expected ahead of packet 1 on a shared output
    for (int j = 0; j < 2; j++) begin
      idx[j] = 0;
      drive_cyc[j] = 0;
      for (int k = 0; k < pkt_n[j]; k++) begin
        drv_flit[j][k] = build_flit(j, k);
        exp_flit[pkt_out[j]][exp_n[pkt_out[j]]] = drv_flit[j][k];
        if (k == 0) begin
          exp_flit[pkt_out[j]][exp_n[pkt_out[j]]].header.routing = pkt_la[j];
        end
        exp_n[pkt_out[j]]++;
      end
    end
    hold_left = hold;
    held_void = void_o[o0];
    held_data = data_o[o0];
    waited = 0;
    while ((idx[0] < pkt_n[0] || idx[1] < pkt_n[1] || hold_left > 0 || stop_i[o0])
           && waited < wait_limit) begin
      if (stop_i[o0] && (void_o[o0] !== held_void || data_o[o0] !== held_data)) begin
        report_error($sformatf("output %0d changed while stop_i was high", o0));
      end
      if (hold_left > 0) begin
        stop_i[o0] = 1'b1;
        hold_left--;
      end else if (stop_i[o0]) begin
        if (pkt_n[0] > queue_depth && (idx[0] != queue_depth || stop_o[pkt_in[0]] !== 1'b1)) begin
          report_error($sformatf("stop_o[%0d] is %b with %0d flits taken, expected 1 with %0d",
                                 pkt_in[0], stop_o[pkt_in[0]], idx[0], queue_depth));
        end
        stop_i[o0] = 1'b0;
      end
      // stop_o only changes at an edge, so its value now decides the next write
      for (int j = 0; j < 2; j++) begin
        take[j] = 1'b0;
        if (idx[j] < pkt_n[j]) begin
          data_i[pkt_in[j]] = drv_flit[j][idx[j]];
          void_i[pkt_in[j]] = 1'b0;
          take[j] = !stop_o[pkt_in[j]];
          if (idx[j] == 0) begin
            drive_cyc[j] = cyc;
          end
        end else if (pkt_n[j] > 0) begin
          void_i[pkt_in[j]] = 1'b1;
        end
      end
      @(posedge clk);
      #2;
      for (int j = 0; j < 2; j++) begin
        if (take[j]) begin
          idx[j]++;
        end
      end
      waited++;
    end
    void_i = '1;
    if (waited >= wait_limit) begin
      abort_run("the router did not accept all flits within 200 cycles");
      return;
    end
    waited = 0;
    while (!all_arrived() && waited < wait_limit) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (!all_arrived()) begin
      abort_run("expected flits did not leave the router within 200 cycles");
      return;
    end
    // Two more cycles so that stray flits show up
    repeat (2) @(posedge clk);
    #2;
    for (int o = 0; o < num_ports; o++) begin
      if (got_n[o] != exp_n[o]) begin
        report_error($sformatf("output %0d gave %0d flits, expected %0d",
                               o, got_n[o], exp_n[o]));
      end else begin
        for (int k = 0; k < got_n[o]; k++) begin
          if (got_flit[o][k] !== exp_flit[o][k]) begin
            report_error($sformatf("output %0d flit %0d is %h, expected %h",
                                   o, k, got_flit[o][k].raw, exp_flit[o][k].raw));
          end
        end
      end
    end
    // Head latency on a free output
    for (int j = 0; j < 2; j++) begin
      if (pkt_n[j] > 0 && hold == 0 && (j == 0 || pkt_out[1] != o0) && got_n[pkt_out[j]] > 0
          && got_cyc[pkt_out[j]][0] != drive_cyc[j] + 1) begin
        report_error($sformatf("head of packet %0d left after %0d cycles, expected 1",
                               j, got_cyc[pkt_out[j]][0] - drive_cyc[j]));
      end
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    bit found;
    int fields;
    int pos_x;
    int pos_y;
    int gap;
    seed = 32'hca13_36df;
    cyc = 0;
    rst = 1'b1;
    position_i = '0;
    data_i = '0;
    void_i = '1;
    stop_i = '0;
    tests_run = 0;
    tests_failed = 0;
    aborted = 1'b0;
    pos_x = 0;
    pos_y = 0;
    for (int o = 0; o < num_ports; o++) begin
      got_n[o] = 0;
    end
    fd = $fopen("verification/router_golden.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open verification/router_golden.txt");
    end else begin
      next_data_line(found);
      if (!found || $sscanf(line, "%d %d", pos_x, pos_y) != 2) begin
        abort_run("the golden file has no router position line");
      end
    end
    position_i.x = coord_width'(pos_x);
    position_i.y = coord_width'(pos_y);
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;

    cur_test = 0;
    test_errors = 0;
    if (void_o !== '1) begin
      report_error($sformatf("void_o is %b after reset, expected all ones", void_o));
    end
    if (stop_o !== '0) begin
      report_error($sformatf("stop_o is %b after reset, expected all zeros", stop_o));
    end
    finish_test();

    found = 1'b0;
    if (!aborted) begin
      next_data_line(found);
    end
    while (found && !aborted) begin
      fields = $sscanf(line, "%d %d %d %d %d %h %d %d %d %d %h %d %d %d %b %b", cur_test,
                       pkt_in[0], pkt_dx[0], pkt_dy[0], pkt_n[0], pkt_pay[0],
                       pkt_in[1], pkt_dx[1], pkt_dy[1], pkt_n[1], pkt_pay[1],
                       hold, pkt_out[0], pkt_out[1], pkt_la[0], pkt_la[1]);
      if (fields != 16) begin
        abort_run("a line of the golden file could not be parsed");
      end else begin
        gap = 1 + ($unsigned($random(seed)) % 4);
        repeat (gap) begin
          @(posedge clk);
          #2;
        end
        run_test();
        finish_test();
        next_data_line(found);
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end

    $display("tests run %0d, passed %0d, failed %0d",
             tests_run, tests_run - tests_failed, tests_failed);
    if (tests_failed == 0 && !aborted) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
